//--- Makefile
# Verilator build for the LCD overlay project.

TOP = tb_lcd_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o sim_lcd
	./obj_dir/sim_lcd | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

//--- layer_mixer.sv
`default_nettype none
`timescale 1ns/1ns
`include "lcd_settings.svh"

module layer_mixer import lcd_pkg::*; (
	input  wire                                 pixel_clk,
	input  wire                                 rst,
	input  lcd_timing_t                         timing,
	input  layer_pixel_t [`LCD_NUM_LAYERS-1:0] pixels,
	output logic                                hsync,
	output logic                                vsync,
	output logic                                den,
	output rgb565_t                             rgb
);

	rgb565_t bg_color;
	rgb565_t mix_color;

	assign bg_color = rgb565_t'({6'b0, timing.x} + {6'b0, timing.y});   // diagonal gradient.

	// later layers overwrite earlier ones.
	always_comb begin
		mix_color = bg_color;
		for (int i = 0; i < `LCD_NUM_LAYERS; i++) begin
			if (pixels[i].opaque) begin
				mix_color = pixels[i].color;
			end
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			den   <= 1'b0;
			rgb   <= '0;
		end else begin
			hsync <= timing.hsync;
			vsync <= timing.vsync;
			den   <= timing.den;
			if (timing.den) begin
				rgb <= mix_color;
			end else begin
				rgb <= '0;   // blank in porches.
			end
		end
	end

endmodule

`default_nettype wire

//--- layer_window.sv
`default_nettype none
`timescale 1ns/1ns
`include "lcd_settings.svh"

module layer_window import lcd_pkg::*; (
	input  wire          pixel_clk,
	input  wire          rst,
	input  lcd_timing_t  timing,
	input  layer_cfg_t   cfg,
	input  vram_wr_t     wr,
	input  vram_addr_t   bus_rd_addr,
	output vram_data_t   bus_rd_data,
	output layer_pixel_t pixel,
	output lcd_timing_t  timing_q
);

	vram_data_t mem [0:`LCD_VRAM_DEPTH-1];

	lcd_coord_t rel_x;
	lcd_coord_t rel_y;
	lcd_coord_t cell_col;
	lcd_coord_t cell_row;
	logic       hit_x;
	logic       hit_y;
	logic       hit;
	vram_addr_t fetch_addr;
	vram_data_t fetch_data;
	logic       hit_q;

	// ---------------------------------------
	// window hit test
	// ---------------------------------------
	assign rel_x = timing.x - cfg.x_org;
	assign rel_y = timing.y - cfg.y_org;

	// rel only trusted once coord is past the origin.
	assign hit_x = (timing.x >= cfg.x_org) && (rel_x < `LCD_WIN_SIZE);
	assign hit_y = (timing.y >= cfg.y_org) && (rel_y < `LCD_WIN_SIZE);
	assign hit   = cfg.en && timing.den && hit_x && hit_y;

	assign cell_col   = rel_x >> `LCD_CELL_SHIFT;
	assign cell_row   = rel_y >> `LCD_CELL_SHIFT;
	assign fetch_addr = {cell_row[`LCD_CELL_BITS-1:0], cell_col[`LCD_CELL_BITS-1:0]};

	// ---------------------------------------
	// video RAM, bus port and fetch port
	// ---------------------------------------
	always_ff @(posedge pixel_clk) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.data;
		end
		bus_rd_data <= mem[bus_rd_addr];   // read before write.
	end

	always_ff @(posedge pixel_clk) begin
		fetch_data <= mem[fetch_addr];
	end

	// timing follows the RAM read.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			hit_q    <= 1'b0;
			timing_q <= TIMING_IDLE;
		end else begin
			hit_q    <= hit;
			timing_q <= timing;
		end
	end

	// byte 0 is see-through.
	assign pixel = '{
		opaque: hit_q && (fetch_data != '0),
		color:  {fetch_data[4:0], fetch_data[5:0], fetch_data[4:0]}
	};

endmodule

`default_nettype wire

//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	typedef logic [9:0]  lcd_coord_t;
	typedef logic [11:0] vram_addr_t;   // {cell row, cell column}.
	typedef logic [7:0]  vram_data_t;
	typedef logic [15:0] rgb565_t;
	typedef logic [15:0] wb_adr_t;
	typedef logic [31:0] wb_data_t;

	typedef struct packed {
		lcd_coord_t x;
		lcd_coord_t y;
		logic       hsync;
		logic       vsync;
		logic       den;
	} lcd_timing_t;

	// syncs idle high, nothing shown.
	localparam lcd_timing_t TIMING_IDLE = '{x: '0, y: '0, hsync: 1'b1, vsync: 1'b1, den: 1'b0};

	typedef struct packed {
		logic       en;
		lcd_coord_t x_org;
		lcd_coord_t y_org;
	} layer_cfg_t;

	typedef struct packed {
		logic    opaque;
		rgb565_t color;
	} layer_pixel_t;

	typedef struct packed {
		logic       we;
		vram_addr_t addr;
		vram_data_t data;
	} vram_wr_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_adr_t  adr;
		wb_data_t dat_w;
	} wb_req_t;

	typedef struct packed {
		logic     ack;
		wb_data_t dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// ---------------------------------------
// 480x272 panel timing at 9 MHz
// ---------------------------------------
`define LCD_H_ACTIVE 480
`define LCD_H_BACK   43    // sync pulse included.
`define LCD_H_FRONT  8
`define LCD_H_PULSE  4
`define LCD_V_ACTIVE 272
`define LCD_V_BACK   12
`define LCD_V_FRONT  8
`define LCD_V_PULSE  4
`define LCD_H_TOTAL  (`LCD_H_BACK + `LCD_H_ACTIVE + `LCD_H_FRONT)
`define LCD_V_TOTAL  (`LCD_V_BACK + `LCD_V_ACTIVE + `LCD_V_FRONT)

// ---------------------------------------
// overlay layers
// ---------------------------------------
`define LCD_NUM_LAYERS  2
`define LCD_WIN_SIZE    256
`define LCD_CELL_SHIFT  2   // each byte covers 4x4 pixels.
`define LCD_CELL_BITS   6   // 64 cells per side.
`define LCD_VRAM_DEPTH  4096

// ---------------------------------------
// bus address map
// ---------------------------------------
`define LCD_BUS_SEL_HI  15
`define LCD_BUS_SEL_LO  14
`define LCD_REG_WORDS   3   // words per layer.
`define LCD_REG_EN      0
`define LCD_REG_X_ORG   1
`define LCD_REG_Y_ORG   2

`endif

//--- lcd_timing.sv
`default_nettype none
`timescale 1ns/1ns
`include "lcd_settings.svh"

module lcd_timing import lcd_pkg::*; (
	input  wire         pixel_clk,
	input  wire         rst,
	output lcd_timing_t timing
);

	lcd_coord_t h_count;
	lcd_coord_t v_count;
	logic       h_last;
	logic       v_last;
	logic       h_act;
	logic       v_act;
	logic       den_next;

	// ---------------------------------------
	// counters
	// ---------------------------------------
	assign h_last = (h_count == `LCD_H_TOTAL - 1);
	assign v_last = (v_count == `LCD_V_TOTAL - 1);

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_last) begin
			h_count <= '0;
			if (v_last) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// ---------------------------------------
	// sync and active window decode
	// ---------------------------------------
	assign h_act = (h_count >= `LCD_H_BACK) && (h_count < `LCD_H_BACK + `LCD_H_ACTIVE);
	assign v_act = (v_count >= `LCD_V_BACK) && (v_count < `LCD_V_BACK + `LCD_V_ACTIVE);
	assign den_next = h_act && v_act;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			timing <= TIMING_IDLE;
		end else begin
			timing.hsync <= (h_count >= `LCD_H_PULSE);   // low at line start.
			timing.vsync <= (v_count >= `LCD_V_PULSE);
			timing.den   <= den_next;
			if (den_next) begin
				timing.x <= lcd_coord_t'(h_count - `LCD_H_BACK);
				timing.y <= lcd_coord_t'(v_count - `LCD_V_BACK);
			end else begin
				timing.x <= '0;
				timing.y <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- lcd_top.sv
`default_nettype none
`timescale 1ns/1ns
`include "lcd_settings.svh"

module lcd_top import lcd_pkg::*; (
	input  wire     pixel_clk,
	input  wire     rst,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output logic    hsync,
	output logic    vsync,
	output logic    den,
	output rgb565_t rgb
);

	lcd_timing_t                          timing;
	lcd_timing_t  [`LCD_NUM_LAYERS-1:0] layer_timing;
	layer_pixel_t [`LCD_NUM_LAYERS-1:0] pixels;
	layer_cfg_t   [`LCD_NUM_LAYERS-1:0] cfg;
	vram_wr_t     [`LCD_NUM_LAYERS-1:0] wr;
	vram_data_t   [`LCD_NUM_LAYERS-1:0] rd_data;
	vram_addr_t                           rd_addr;

	lcd_timing u_timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.timing    (timing)
	);

	// ---------------------------------------
	// overlay layers
	// ---------------------------------------
	for (genvar i = 0; i < `LCD_NUM_LAYERS; i++) begin : g_layer
		layer_window u_layer (
			.pixel_clk   (pixel_clk),
			.rst         (rst),
			.timing      (timing),
			.cfg         (cfg[i]),
			.wr          (wr[i]),
			.bus_rd_addr (rd_addr),
			.bus_rd_data (rd_data[i]),
			.pixel       (pixels[i]),
			.timing_q    (layer_timing[i])
		);
	end

	layer_mixer u_mixer (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.timing    (layer_timing[0]),   // all layers share the delay.
		.pixels    (pixels),
		.hsync     (hsync),
		.vsync     (vsync),
		.den       (den),
		.rgb       (rgb)
	);

	wb_layer_regs u_regs (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.cfg       (cfg),
		.wr        (wr),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

endmodule

`default_nettype wire

//--- tb_lcd_top.sv
`default_nettype none
`timescale 1ns/1ns
`include "lcd_settings.svh"

module tb_lcd_top import lcd_pkg::*; ();

	localparam int NL            = `LCD_NUM_LAYERS;
	localparam int DRIVE_DELAY   = 10;
	localparam int ACK_TIMEOUT   = 8;
	localparam int FRAME_TIMEOUT = 200000;

	logic       pixel_clk;
	logic       rst;
	wb_req_t    wb_req;
	wb_rsp_t    wb_rsp;
	logic       hsync;
	logic       vsync;
	logic       den;
	rgb565_t    rgb;
	logic [31:0] rng_state;
	int         err_count;
	int         tests_run;
	int         tests_failed;

	rgb565_t    frame [0:271][0:479];
	int         mon_row;
	int         mon_col;
	logic       mon_vs_prev;
	logic       mon_den_prev;

	// reference model of the layer registers and RAMs.
	logic       m_en [0:NL-1];
	lcd_coord_t m_x [0:NL-1];
	lcd_coord_t m_y [0:NL-1];
	vram_data_t vram_model [0:NL-1][0:4095];

	lcd_top dut (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.hsync     (hsync),
		.vsync     (vsync),
		.den       (den),
		.rgb       (rgb)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #50 pixel_clk = ~pixel_clk;
	end

	// ----------------------------------------
	// screen capture
	// ----------------------------------------
	initial begin
		mon_row = 272;   // nothing stored before the first vsync.
		mon_col = 0;
		mon_vs_prev = 1'b1;
		mon_den_prev = 1'b0;
	end

	always @(negedge pixel_clk) begin
		if (mon_vs_prev && !vsync) begin
			mon_row = 0;
			mon_col = 0;
		end
		if (den) begin
			if (mon_row < 272 && mon_col < 480)
				frame[mon_row][mon_col] = rgb;
			mon_col++;
		end else if (mon_den_prev) begin
			mon_col = 0;
			mon_row++;
		end
		mon_vs_prev = vsync;
		mon_den_prev = den;
	end

	// ----------------------------------------
	// helpers and compare tasks
	// ----------------------------------------
	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic wb_adr_t reg_addr(int n, int k);
		return wb_adr_t'(3 * n + k);
	endfunction

	function automatic wb_adr_t ram_addr(int n, vram_addr_t a);
		return {2'(n + 1), 2'b00, a};
	endfunction

	function automatic rgb565_t expected_rgb(int x, int y);
		rgb565_t    c;
		vram_data_t d;
		int         n;
		logic       in_x;
		logic       in_y;
		c = rgb565_t'(x + y);   // background gradient.
		for (n = 0; n < NL; n++) begin
			in_x = (x >= m_x[n]) && (x < m_x[n] + 256);
			in_y = (y >= m_y[n]) && (y < m_y[n] + 256);
			if (m_en[n] && in_x && in_y) begin
				d = vram_model[n][((y - m_y[n]) >> 2) * 64 + ((x - m_x[n]) >> 2)];
				if (d != 8'h00)
					c = {d[4:0], d[5:0], d[4:0]};
			end
		end
		return c;
	endfunction

	task automatic check_rgb(string name, rgb565_t got, rgb565_t exp);
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(string name, wb_data_t got, wb_data_t exp);
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic stop_on_timeout(string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Test failures found");
		$finish;
	endtask

	task automatic report_test(string name, int errs_before);
		tests_run++;
		if (err_count == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic wait_ack(output wb_data_t dat);
		int   n;
		logic seen;
		seen = 1'b0;
		dat = '0;
		for (n = 0; n < ACK_TIMEOUT; n++) begin
			@(negedge pixel_clk);
			if (wb_rsp.ack) begin
				seen = 1'b1;
				dat = wb_rsp.dat_r;
				break;
			end
		end
		if (!seen) begin
			stop_on_timeout("bus access was never acknowledged");
		end else begin
			@(posedge pixel_clk);
			#DRIVE_DELAY;
			wb_req = '0;
		end
	endtask

	task automatic wb_write(wb_adr_t adr, wb_data_t data);
		wb_data_t unused;
		@(posedge pixel_clk);
		#DRIVE_DELAY;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
		wait_ack(unused);
	endtask

	task automatic wb_read(wb_adr_t adr, output wb_data_t data);
		@(posedge pixel_clk);
		#DRIVE_DELAY;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: '0};
		wait_ack(data);
	endtask

	task automatic wait_frame();
		int   n;
		logic prev;
		logic seen;
		seen = 1'b0;
		prev = vsync;
		for (n = 0; n < FRAME_TIMEOUT; n++) begin
			@(negedge pixel_clk);
			if (prev && !vsync) begin
				seen = 1'b1;
				break;
			end
			prev = vsync;
		end
		if (!seen)
			stop_on_timeout("no vsync falling edge within 200000 clocks");
	endtask

	task automatic set_layer(int n, logic en, lcd_coord_t x, lcd_coord_t y);
		wb_write(reg_addr(n, 0), {31'b0, en});
		wb_write(reg_addr(n, 1), {22'b0, x});
		wb_write(reg_addr(n, 2), {22'b0, y});
		m_en[n] = en;
		m_x[n] = x;
		m_y[n] = y;
	endtask

	task automatic fill_vram(int n);
		logic [31:0] r;
		vram_data_t  b;
		int          a;
		for (a = 0; a < 4096; a++) begin
			r = xorshift32();
			b = (r[15:13] == 3'd0) ? 8'h00 : r[7:0];   // about one in eight clear.
			vram_model[n][a] = b;
			wb_write(ram_addr(n, vram_addr_t'(a)), {24'b0, b});
		end
	endtask

	task automatic check_frame(string tag);
		int x;
		int y;
		wait_frame();   // new settings apply from here.
		wait_frame();
		for (y = 0; y < 272; y++)
			for (x = 0; x < 480; x++)
				check_rgb($sformatf("%s rgb(%0d,%0d)", tag, x, y), frame[y][x],
					expected_rgb(x, y));
	endtask

	task automatic check_idle();
		check_bit("hsync", hsync, 1'b1);
		check_bit("vsync", vsync, 1'b1);
		check_bit("den", den, 1'b0);
		check_rgb("rgb", rgb, 16'h0000);
		check_bit("ack", wb_rsp.ack, 1'b0);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic reset_state();
		int errs;
		errs = err_count;
		@(negedge pixel_clk);
		check_idle();
		@(posedge pixel_clk);
		#DRIVE_DELAY;
		rst = 1'b1;
		@(negedge pixel_clk);
		check_idle();   // pipeline still empty.
		report_test("reset state", errs);
	endtask

	task automatic bus_access();
		int         errs;
		int         n;
		int         k;
		int         j;
		wb_data_t   val;
		wb_data_t   got;
		vram_addr_t a;
		errs = err_count;
		for (n = 0; n < NL; n++) begin
			for (k = 0; k < 3; k++) begin
				val = xorshift32();
				wb_write(reg_addr(n, k), val);
				wb_read(reg_addr(n, k), got);
				check_word($sformatf("reg %0d.%0d", n, k), got,
					val & ((k == 0) ? 32'h1 : 32'h3ff));
			end
			for (j = 0; j < 8; j++) begin
				val = xorshift32();
				a = val[27:16];
				wb_write(ram_addr(n, a), {24'b0, val[7:0]});
				wb_read(ram_addr(n, a), got);
				check_word($sformatf("vram %0d[%0d]", n, a), got, {24'b0, val[7:0]});
			end
		end
		wb_read(16'hc000, got);
		check_word("unmapped ram target", got, 32'h0);
		wb_read(reg_addr(NL, 0), got);
		check_word("unmapped register", got, 32'h0);
		report_test("bus access", errs);
	endtask

	task automatic panel_timing();
		int   errs;
		int   n;
		int   h_period;
		int   h_low;
		int   den_run;
		int   den_lines;
		int   lines;
		logic prev_h;
		logic prev_d;
		logic prev_v;
		logic done;
		errs = err_count;
		wait_frame();   // hsync falls together with vsync.
		h_period = 0;
		h_low = 1;
		den_run = 0;
		den_lines = 0;
		lines = 0;
		done = 1'b0;
		prev_h = hsync;
		prev_d = den;
		prev_v = vsync;
		for (n = 0; n < FRAME_TIMEOUT; n++) begin
			@(negedge pixel_clk);
			h_period++;
			if (!hsync)
				h_low++;
			if (den)
				den_run++;
			else
				check_rgb("rgb in blanking", rgb, 16'h0000);
			if (prev_h && !hsync) begin
				check_word("hsync period", h_period, 531);
				h_period = 0;
				lines++;
			end
			if (!prev_h && hsync) begin
				check_word("hsync low width", h_low, 4);
				h_low = 0;
			end
			if (prev_d && !den) begin
				check_word("den clocks per line", den_run, 480);
				den_run = 0;
				den_lines++;
			end
			if (prev_v && !vsync) begin
				done = 1'b1;
				break;
			end
			prev_h = hsync;
			prev_d = den;
			prev_v = vsync;
		end
		if (!done) begin
			stop_on_timeout("second vsync falling edge never came");
		end else begin
			check_word("lines per frame", lines, 292);
			check_word("den lines per frame", den_lines, 272);
			report_test("panel timing", errs);
		end
	endtask

	task automatic background();
		int errs;
		int n;
		errs = err_count;
		for (n = 0; n < NL; n++)
			set_layer(n, 1'b0, '0, '0);
		check_frame("background");
		report_test("background", errs);
	endtask

	task automatic single_layer();
		int errs;
		errs = err_count;
		fill_vram(0);
		set_layer(0, 1'b1, 10'd100, 10'd10);
		check_frame("layer 0");
		report_test("single layer", errs);
	endtask

	task automatic layer_priority();
		int errs;
		errs = err_count;
		fill_vram(1);
		set_layer(1, 1'b1, 10'd200, 10'd100);   // overlaps layer 0 and is clipped at the bottom.
		check_frame("layers 0 and 1");
		set_layer(1, 1'b0, 10'd200, 10'd100);
		check_frame("layer 1 off");
		report_test("layer priority", errs);
	endtask

	initial begin
		rst = 1'b0;
		wb_req = '0;
		rng_state = 32'hd3b2;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (2) @(posedge pixel_clk);
		reset_state();
		bus_access();
		panel_timing();
		background();
		single_layer();
		layer_priority();
		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
lcd_pkg.sv
lcd_timing.sv
layer_window.sv
layer_mixer.sv
wb_layer_regs.sv
lcd_top.sv
tb_lcd_top.sv

//--- wb_layer_regs.sv
`default_nettype none
`timescale 1ns/1ns
`include "lcd_settings.svh"

module wb_layer_regs import lcd_pkg::*; (
	input  wire                              pixel_clk,
	input  wire                              rst,
	input  wb_req_t                          wb_req,
	output wb_rsp_t                          wb_rsp,
	output layer_cfg_t [`LCD_NUM_LAYERS-1:0] cfg,
	output vram_wr_t   [`LCD_NUM_LAYERS-1:0] wr,
	output vram_addr_t                       rd_addr,
	input  vram_data_t [`LCD_NUM_LAYERS-1:0] rd_data
);

	logic        ack_q;
	logic        req;
	logic [1:0]  sel;
	logic [1:0]  layer_idx;
	logic [13:0] word;
	logic        is_reg;
	logic        ram_hit;
	wb_data_t    reg_rd;
	wb_data_t    reg_rd_q;
	logic        ram_rd_q;
	logic [1:0]  layer_q;
	wb_data_t    rd_word;

	// ---------------------------------------
	// address decode
	// ---------------------------------------
	assign req       = wb_req.cyc && wb_req.stb && !ack_q;   // one ack per access.
	assign sel       = wb_req.adr[`LCD_BUS_SEL_HI:`LCD_BUS_SEL_LO];
	assign word      = wb_req.adr[13:0];
	assign is_reg    = (sel == 2'd0);
	assign layer_idx = sel - 2'd1;
	assign ram_hit   = !is_reg && (layer_idx < `LCD_NUM_LAYERS);
	assign rd_addr   = wb_req.adr[11:0];

	always_comb begin
		for (int i = 0; i < `LCD_NUM_LAYERS; i++) begin
			wr[i].we   = req && wb_req.we && ram_hit && (layer_idx == i);
			wr[i].addr = wb_req.adr[11:0];
			wr[i].data = wb_req.dat_w[7:0];
		end
	end

	// ---------------------------------------
	// window registers
	// ---------------------------------------
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			ack_q <= 1'b0;
			cfg   <= '0;   // all layers off.
		end else begin
			ack_q <= req;
			for (int i = 0; i < `LCD_NUM_LAYERS; i++) begin
				if (req && wb_req.we && is_reg) begin
					if (word == `LCD_REG_WORDS * i + `LCD_REG_EN)
						cfg[i].en <= wb_req.dat_w[0];
					if (word == `LCD_REG_WORDS * i + `LCD_REG_X_ORG)
						cfg[i].x_org <= wb_req.dat_w[9:0];
					if (word == `LCD_REG_WORDS * i + `LCD_REG_Y_ORG)
						cfg[i].y_org <= wb_req.dat_w[9:0];
				end
			end
		end
	end

	always_comb begin
		reg_rd = '0;   // unmapped words read zero.
		for (int i = 0; i < `LCD_NUM_LAYERS; i++) begin
			if (word == `LCD_REG_WORDS * i + `LCD_REG_EN)
				reg_rd = {31'b0, cfg[i].en};
			if (word == `LCD_REG_WORDS * i + `LCD_REG_X_ORG)
				reg_rd = {22'b0, cfg[i].x_org};
			if (word == `LCD_REG_WORDS * i + `LCD_REG_Y_ORG)
				reg_rd = {22'b0, cfg[i].y_org};
		end
	end

	// ---------------------------------------
	// read return
	// ---------------------------------------
	always_ff @(posedge pixel_clk) begin
		if (req) begin
			reg_rd_q <= is_reg ? reg_rd : '0;
			ram_rd_q <= ram_hit;
			layer_q  <= layer_idx;
		end
	end

	// RAM byte arrives with the ack.
	always_comb begin
		rd_word = reg_rd_q;
		for (int i = 0; i < `LCD_NUM_LAYERS; i++) begin
			if (ram_rd_q && (layer_q == i))
				rd_word = {24'b0, rd_data[i]};
		end
	end

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.dat_r = ack_q ? rd_word : '0;

endmodule

`default_nettype wire
